// File: filelist.f
hw/rv_pkg.sv
hw/rv_ctrl_if.sv
hw/rv_alu_dec.sv
hw/rv_alu.sv
hw/rv_regfile.sv
hw/rv_imm_ext.sv
hw/rv_mcyc_ctrl.sv
hw/rv_datapath.sv
hw/rv_mcyc_core.sv
verif/rv_mcyc_assertions.sv
verif/tb_rv_mcyc_core.sv

// File: Bender.yml
package:
  name: rv_mcyc_core

sources:
  - hw/rv_pkg.sv
  - hw/rv_ctrl_if.sv
  - hw/rv_alu_dec.sv
  - hw/rv_alu.sv
  - hw/rv_regfile.sv
  - hw/rv_imm_ext.sv
  - hw/rv_mcyc_ctrl.sv
  - hw/rv_datapath.sv
  - hw/rv_mcyc_core.sv
  - target: test
    files:
      - verif/rv_mcyc_assertions.sv
      - verif/tb_rv_mcyc_core.sv

// File: verif/tb_rv_mcyc_core.sv
`timescale 1ns/1ps

module tb_rv_mcyc_core
    import rv_pkg::*;
();
    localparam int          MEM_WORDS  = 256;
    localparam int          MAX_CYCLES = 2000;
    localparam logic [31:0] VAL_A      = 32'h0000_035C;
    localparam logic [31:0] VAL_B      = 32'hFFFF_FFF9; // -7
    localparam logic [31:0] DATA0      = 32'h1234_C6A5;
    localparam logic [31:0] DATA1      = 32'h5A6B_7C1D;

    logic        clk;
    logic        rst;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic [31:0] mem_rdata;
    logic        mem_we;
    mem_dt_e     mem_dt;
    logic        trap;

    logic [31:0] mem [MEM_WORDS];
    logic [31:0] prog_addr [$];
    logic [31:0] prog_word [$];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    mem_dt_e     exp_dt [$];
    int          pc_asm;
    int          st_off;   // next free offset from x1
    int          errors;
    int          stores;

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    rv_mcyc_core #(
        .RESET_PC (32'h0000_0000)
    ) i_dut (
        .clk       (clk),
        .rst       (rst),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .mem_we    (mem_we),
        .mem_dt    (mem_dt),
        .trap      (trap)
    );

    bind rv_mcyc_core rv_mcyc_assertions i_assertions (
        .clk    (clk),
        .rst    (rst),
        .mem_we (mem_we),
        .trap   (trap)
    );

    function automatic logic [31:0] lane_mask(input mem_dt_e dt, input logic [1:0] low);
        case (dt)
            MEM_DT_BYTE, MEM_DT_UBYTE: lane_mask = 32'h0000_00FF << (8 * low);
            MEM_DT_HALF, MEM_DT_UHALF: lane_mask = 32'h0000_FFFF << (16 * low[1]);
            default:                   lane_mask = 32'hFFFF_FFFF;
        endcase
    endfunction

    assign mem_rdata = mem[mem_addr[9:2]];

    always @(posedge clk) begin
        if (mem_we) begin
            mem[mem_addr[9:2]] <= (mem[mem_addr[9:2]] & ~lane_mask(mem_dt, mem_addr[1:0]))
                                | (mem_wdata & lane_mask(mem_dt, mem_addr[1:0]));
        end
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, actual, expected);
            errors++;
        end
    endtask

    task automatic emit(input logic [31:0] word);
        prog_addr.push_back(pc_asm);
        prog_word.push_back(word);
        pc_asm += 4;
    endtask

    task automatic place_word(input logic [31:0] addr, input logic [31:0] word);
        prog_addr.push_back(addr);
        prog_word.push_back(word);
    endtask

    task automatic reg_op(input logic [6:0] f7, input logic [4:0] rs2, input logic [4:0] rs1,
                          input logic [2:0] f3, input logic [4:0] rd);
        emit({f7, rs2, rs1, f3, rd, 7'b0110011});
    endtask

    task automatic imm_op(input logic [11:0] imm, input logic [4:0] rs1,
                          input logic [2:0] f3, input logic [4:0] rd);
        emit({imm, rs1, f3, rd, 7'b0010011});
    endtask

    task automatic ld(input logic [11:0] imm, input logic [4:0] rs1,
                      input logic [2:0] f3, input logic [4:0] rd);
        emit({imm, rs1, f3, rd, 7'b0000011});
    endtask

    task automatic st(input logic [11:0] imm, input logic [4:0] rs2, input logic [4:0] rs1,
                      input logic [2:0] f3);
        emit({imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011});
    endtask

    task automatic br(input logic [12:0] imm, input logic [4:0] rs2, input logic [4:0] rs1,
                      input logic [2:0] f3);
        emit({imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011});
    endtask

    task automatic jal(input logic [20:0] imm, input logic [4:0] rd);
        emit({imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111});
    endtask

    task automatic jalr(input logic [11:0] imm, input logic [4:0] rs1, input logic [4:0] rd);
        emit({imm, rs1, 3'b000, rd, 7'b1100111});
    endtask

    task automatic lui(input logic [19:0] imm, input logic [4:0] rd);
        emit({imm, rd, 7'b0110111});
    endtask

    task automatic expect_store(input logic [31:0] addr, input logic [31:0] value,
                                input mem_dt_e dt);
        exp_addr.push_back(addr);
        case (dt)
            MEM_DT_BYTE: exp_data.push_back({4{value[7:0]}});
            MEM_DT_HALF: exp_data.push_back({2{value[15:0]}});
            default:     exp_data.push_back(value);
        endcase
        exp_dt.push_back(dt);
    endtask

    task automatic store_reg(input logic [4:0] rs, input logic [31:0] value);
        st(st_off[11:0], rs, 5'd1, 3'b010);
        expect_store(32'h300 + st_off, value, MEM_DT_WORD);
        st_off += 4;
    endtask

    task automatic dead_store(input logic [4:0] rs); // must be skipped
        st(st_off[11:0], rs, 5'd1, 3'b010);
        st_off += 4;
    endtask

    task automatic branch_case(input logic [2:0] f3, input logic [4:0] rs1,
                               input logic [4:0] rs2, input bit taken);
        br(13'd8, rs2, rs1, f3);
        if (taken) begin
            dead_store(9);
        end else begin
            store_reg(9, 32'h77);
        end
    endtask

    task automatic build_program();
        int link;
        int tgt;
        pc_asm = 0;
        st_off = 0;
        place_word(32'h200, DATA0);
        place_word(32'h204, DATA1);
        imm_op(12'h300, 0, 3'b000, 1);          // store base
        imm_op(12'h200, 0, 3'b000, 2);          // data base
        imm_op(VAL_A[11:0], 0, 3'b000, 3);
        imm_op(VAL_B[11:0], 0, 3'b000, 4);
        imm_op(12'd4, 0, 3'b000, 6);
        imm_op(12'h077, 0, 3'b000, 9);          // fall-through marker
        reg_op(7'h00, 4, 3, 3'b000, 5);
        store_reg(5, VAL_A + VAL_B);
        reg_op(7'h20, 4, 3, 3'b000, 5);
        store_reg(5, VAL_A - VAL_B);
        reg_op(7'h00, 4, 3, 3'b111, 5);
        store_reg(5, VAL_A & VAL_B);
        reg_op(7'h00, 4, 3, 3'b110, 5);
        store_reg(5, VAL_A | VAL_B);
        reg_op(7'h00, 4, 3, 3'b100, 5);
        store_reg(5, VAL_A ^ VAL_B);
        reg_op(7'h00, 6, 3, 3'b001, 5);
        store_reg(5, VAL_A << 4);
        reg_op(7'h00, 6, 4, 3'b101, 5);
        store_reg(5, VAL_B >> 4);
        reg_op(7'h20, 6, 4, 3'b101, 5);
        store_reg(5, $signed(VAL_B) >>> 4);
        reg_op(7'h00, 3, 4, 3'b010, 5);
        store_reg(5, {31'd0, $signed(VAL_B) < $signed(VAL_A)});
        reg_op(7'h00, 3, 4, 3'b011, 5);
        store_reg(5, {31'd0, VAL_B < VAL_A});
        imm_op(12'h123, 3, 3'b000, 5);
        store_reg(5, VAL_A + 32'h123);
        imm_op(12'hFFF, 3, 3'b011, 5);
        store_reg(5, {31'd0, VAL_A < 32'hFFFF_FFFF});
        imm_op(12'hFFA, 4, 3'b010, 5);
        store_reg(5, {31'd0, $signed(VAL_B) < $signed(32'hFFFF_FFFA)});
        imm_op(12'h0F0, 4, 3'b111, 5);
        store_reg(5, VAL_B & 32'h0F0);
        imm_op(12'hFF0, 3, 3'b110, 5);
        store_reg(5, VAL_A | 32'hFFFF_FFF0);
        imm_op(12'h555, 4, 3'b100, 5);
        store_reg(5, VAL_B ^ 32'h555);
        imm_op(12'h003, 3, 3'b001, 5);
        store_reg(5, VAL_A << 3);
        imm_op(12'h01C, 4, 3'b101, 5);
        store_reg(5, VAL_B >> 28);
        imm_op(12'h405, 4, 3'b101, 5);          // srai by 5
        store_reg(5, $signed(VAL_B) >>> 5);
        ld(12'd0, 2, 3'b000, 5);
        store_reg(5, {{24{DATA0[7]}}, DATA0[7:0]});
        ld(12'd0, 2, 3'b100, 5);
        store_reg(5, {24'd0, DATA0[7:0]});
        ld(12'd0, 2, 3'b001, 5);
        store_reg(5, {{16{DATA0[15]}}, DATA0[15:0]});
        ld(12'd0, 2, 3'b101, 5);
        store_reg(5, {16'd0, DATA0[15:0]});
        ld(12'd0, 2, 3'b010, 5);
        store_reg(5, DATA0);
        ld(12'd4, 2, 3'b000, 5);
        store_reg(5, {{24{DATA1[7]}}, DATA1[7:0]});
        ld(12'd4, 2, 3'b001, 5);
        store_reg(5, {{16{DATA1[15]}}, DATA1[15:0]});
        ld(12'd1, 2, 3'b000, 5);                // byte lane 1
        store_reg(5, {{24{DATA0[15]}}, DATA0[15:8]});
        ld(12'd3, 2, 3'b100, 5);                // byte lane 3
        store_reg(5, {24'd0, DATA0[31:24]});
        ld(12'd2, 2, 3'b001, 5);                // upper half
        store_reg(5, {{16{DATA0[31]}}, DATA0[31:16]});
        ld(12'd6, 2, 3'b101, 5);
        store_reg(5, {16'd0, DATA1[31:16]});
        st(12'h040, 3, 2, 3'b010);
        expect_store(32'h240, VAL_A, MEM_DT_WORD);
        st(12'h041, 4, 2, 3'b000);              // byte lane 1
        expect_store(32'h241, VAL_B, MEM_DT_BYTE);
        st(12'h044, 4, 2, 3'b010);
        expect_store(32'h244, VAL_B, MEM_DT_WORD);
        st(12'h046, 3, 2, 3'b001);              // upper half
        expect_store(32'h246, VAL_A, MEM_DT_HALF);
        ld(12'h040, 2, 3'b010, 7);
        store_reg(7, {VAL_A[31:16], VAL_B[7:0], VAL_A[7:0]});
        ld(12'h044, 2, 3'b010, 7);
        store_reg(7, {VAL_A[15:0], VAL_B[15:0]});
        lui(20'hABCDE, 8);
        store_reg(8, 32'hABCD_E000);
        branch_case(3'b000, 3, 3, 1'b1);
        branch_case(3'b000, 3, 4, 1'b0);
        branch_case(3'b001, 3, 4, 1'b1);
        branch_case(3'b001, 3, 3, 1'b0);
        branch_case(3'b100, 4, 3, 1'b1);
        branch_case(3'b100, 3, 4, 1'b0);
        branch_case(3'b101, 3, 4, 1'b1);
        branch_case(3'b101, 4, 3, 1'b0);
        branch_case(3'b110, 3, 4, 1'b1);
        branch_case(3'b110, 4, 3, 1'b0);
        branch_case(3'b111, 4, 3, 1'b1);
        branch_case(3'b111, 3, 4, 1'b0);
        imm_op(12'd3, 0, 3'b000, 10);
        imm_op(12'd0, 0, 3'b000, 11);
        imm_op(12'hFFF, 10, 3'b000, 10);        // loop body
        imm_op(12'd5, 11, 3'b000, 11);
        br(-13'sd8, 0, 10, 3'b001);             // back while x10 != 0
        store_reg(11, 32'd15);
        link = pc_asm;
        jal(21'd8, 12);
        dead_store(9);
        store_reg(12, link + 4);
        tgt = pc_asm + 9;                       // odd, target at +12 after imm 4
        imm_op(tgt[11:0], 0, 3'b000, 14);
        link = pc_asm;
        jalr(12'd4, 14, 15);
        dead_store(9);
        store_reg(15, link + 4);
        link = pc_asm;
        jal(21'd4, 13);                         // link exposes a misaligned pc
        store_reg(13, link + 4);
        emit(32'h0000_0000);                    // illegal, halts the core
        dead_store(9);
    endtask

    always @(negedge clk) begin
        if (!rst && mem_we) begin
            if (stores < exp_addr.size()) begin
                check_value(mem_addr, exp_addr[stores], $sformatf("store %0d address", stores));
                check_value(mem_wdata, exp_data[stores], $sformatf("store %0d data", stores));
                check_value(32'(mem_dt), 32'(exp_dt[stores]),
                            $sformatf("store %0d data type", stores));
            end else begin
                $display("ERROR at %0t: unexpected extra store to %h", $time, mem_addr);
                errors++;
            end
            stores++;
        end
    end

    initial begin
        int cycles;
        rst    = 1'b0;
        errors = 0;
        stores = 0;
        build_program();
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] <= 32'hD00D_0000 | i;
        end
        for (int k = 0; k < prog_addr.size(); k++) begin
            mem[prog_addr[k][9:2]] <= prog_word[k];
        end
        #1;
        rst    = 1'b1;
        repeat (8) @(posedge clk);
        #1;
        rst    = 1'b0;
        cycles = 0;
        while (!trap && cycles < MAX_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (!trap) begin
            $display("ERROR: the core never halted within %0d cycles", MAX_CYCLES);
            errors++;
        end
        repeat (4) @(negedge clk); // nothing may be stored after the trap
        check_value(stores, exp_addr.size(), "number of stores");
        errors += i_dut.i_assertions.fails;
        $display("errors: %0d, stores seen: %0d of %0d", errors, stores, exp_addr.size());
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end
endmodule

// File: verif/rv_mcyc_assertions.sv
`timescale 1ns/1ps

module rv_mcyc_assertions (
    input logic clk,
    input logic rst,
    input logic mem_we,
    input logic trap
);
    int fails = 0; // assertion failures so far

    // store strobe lasts a single cycle
    we_one_cycle: assert property (@(posedge clk) disable iff (rst) mem_we |=> !mem_we)
        else begin
            $error("mem_we high two cycles in a row");
            fails++;
        end

    trap_sticky: assert property (@(posedge clk) disable iff (rst) trap |=> trap)
        else begin
            $error("trap dropped without reset");
            fails++;
        end

    no_we_in_trap: assert property (@(posedge clk) disable iff (rst) trap |-> !mem_we)
        else begin
            $error("mem_we high while trap is set");
            fails++;
        end

    quiet_in_reset: assert property (@(posedge clk) rst |-> (!mem_we && !trap))
        else begin
            $error("mem_we or trap high during reset");
            fails++;
        end
endmodule

// File: hw/rv_mcyc_core.sv
`timescale 1ns/1ps

module rv_mcyc_core
    import rv_pkg::*;
#(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input  logic        clk,
    input  logic        rst,
    output logic [31:0] mem_addr,
    output logic [31:0] mem_wdata,
    input  logic [31:0] mem_rdata,
    output logic        mem_we,
    output mem_dt_e     mem_dt,
    output logic        trap
);
    rv_ctrl_if ctrl_if ();

    rv_mcyc_ctrl i_ctrl (
        .clk  (clk),
        .rst  (rst),
        .ctrl (ctrl_if.ctrl),
        .trap (trap)
    );

    rv_datapath #(
        .RESET_PC (RESET_PC)
    ) i_datapath (
        .clk       (clk),
        .rst       (rst),
        .ctrl      (ctrl_if.dp),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .mem_we    (mem_we),
        .mem_dt    (mem_dt)
    );
endmodule

// File: hw/rv_datapath.sv
`timescale 1ns/1ps

module rv_datapath
    import rv_pkg::*;
#(
    parameter logic [31:0] RESET_PC
) (
    input  logic        clk,
    input  logic        rst,
    rv_ctrl_if.dp       ctrl,
    output logic [31:0] mem_addr,
    output logic [31:0] mem_wdata,
    input  logic [31:0] mem_rdata,
    output logic        mem_we,
    output mem_dt_e     mem_dt
);
    logic [31:0] pc, old_pc, ir, alu_out, mem_data;
    logic [31:0] src_a, src_b, alu_result, result;
    logic [31:0] rd1, rd2, imm, rf_wd, load_data;
    logic [7:0]  ld_byte;
    logic [15:0] ld_half;
    rv_flags_t   flags;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= RESET_PC;
        end else if (ctrl.en_npc_r) begin
            pc <= (ctrl.pc_src == PC_SRC_RES_ALIGN) ? {result[31:1], 1'b0} : result;
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.en_ir) begin
            ir <= mem_rdata;
        end
        if (ctrl.en_oldpc_r) begin
            old_pc <= pc;
        end
        alu_out  <= alu_result; // every cycle, read back next state
        mem_data <= mem_rdata;
    end

    always_comb begin
        case (ctrl.alu_src_a)
            ALU_SRC_PC:     src_a = pc;
            ALU_SRC_PC_OLD: src_a = old_pc;
            ALU_SRC_REG_1:  src_a = rd1;
            default:        src_a = '0;
        endcase
        case (ctrl.alu_src_b)
            ALU_SRC_4:       src_b = 32'd4;
            ALU_SRC_EXT_IMM: src_b = imm;
            ALU_SRC_REG_2:   src_b = rd2;
            default:         src_b = '0;
        endcase
    end

    // lane pick by low address bits
    assign ld_byte = mem_data[8*alu_out[1:0] +: 8];
    assign ld_half = alu_out[1] ? mem_data[31:16] : mem_data[15:0];

    always_comb begin
        case (ctrl.dt)
            MEM_DT_BYTE:  load_data = {{24{ld_byte[7]}}, ld_byte};
            MEM_DT_UBYTE: load_data = {24'd0, ld_byte};
            MEM_DT_HALF:  load_data = {{16{ld_half[15]}}, ld_half};
            MEM_DT_UHALF: load_data = {16'd0, ld_half};
            default:      load_data = mem_data;
        endcase
        case (ctrl.res_src)
            RES_SRC_ALU:     result = alu_result;
            RES_SRC_ALU_OUT: result = alu_out;
            RES_SRC_MEM:     result = load_data;
            default:         result = '0;
        endcase
        case (ctrl.rf_wd_src)
            RF_WD_SRC_PC:  rf_wd = pc;  // already old pc + 4
            RF_WD_SRC_IMM: rf_wd = imm;
            default:       rf_wd = result;
        endcase
        case (ctrl.dt)
            MEM_DT_BYTE: mem_wdata = {4{rd2[7:0]}};
            MEM_DT_HALF: mem_wdata = {2{rd2[15:0]}};
            default:     mem_wdata = rd2;
        endcase
    end

    assign mem_addr        = ctrl.m_addr_src ? alu_out : pc;
    assign mem_we          = ctrl.m_we;
    assign mem_dt          = ctrl.dt;
    assign ctrl.instr      = ir;
    assign ctrl.alu_flags  = flags;

    rv_alu i_alu (.a(src_a), .b(src_b), .op(ctrl.alu_ctrl), .result(alu_result), .flags(flags));

    rv_regfile i_regfile (
        .clk (clk),
        .rst (rst),
        .ra1 (ir[19:15]),
        .ra2 (ir[24:20]),
        .wa  (ir[11:7]),
        .wd  (rf_wd),
        .we  (ctrl.rf_we),
        .rd1 (rd1),
        .rd2 (rd2)
    );

    rv_imm_ext i_imm_ext (.instr(ir), .imm_src(ctrl.imm_src), .imm(imm));
endmodule

// File: hw/rv_mcyc_ctrl.sv
`timescale 1ns/1ps

module rv_mcyc_ctrl
    import rv_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    rv_ctrl_if.ctrl ctrl,
    output logic  trap
);
    typedef enum logic [3:0] {
        FETCH, DECODE, MEM_ADDR, MEM_READ, MEM_WRITE, MEM_W_RF, EXEC, ALU_W_RF,
        BRANCH, ALU_W_PCN, EXEC_I_JALR, EXEC_J, EXEC_LUI, ERROR
    } state_e;

    state_e     cs;
    state_e     decode_ns;
    logic [6:0] op;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       is_load;
    logic       take_branch;
    mem_dt_e    mem_dt;
    imm_src_e   exec_imm_src;
    alu_op_e    alu_dec_op;

    assign op      = ctrl.instr[6:0];
    assign funct3  = ctrl.instr[14:12];
    assign funct7  = ctrl.instr[31:25];
    assign is_load = (op == OP_I_TYPE_L);
    assign trap    = (cs == ERROR);

    always_comb begin
        case (op)
            OP_R_TYPE, OP_I_TYPE:   decode_ns = EXEC;
            OP_I_TYPE_L, OP_S_TYPE: decode_ns = MEM_ADDR;
            OP_B_TYPE:              decode_ns = BRANCH;
            OP_J_TYPE:              decode_ns = EXEC_J;
            OP_JALR:                decode_ns = EXEC_I_JALR;
            OP_LUI:                 decode_ns = EXEC_LUI;
            default:                decode_ns = ERROR;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cs <= FETCH;
        end else begin
            case (cs)
                FETCH:       cs <= DECODE;
                DECODE:      cs <= decode_ns;
                MEM_ADDR:    cs <= is_load ? MEM_READ : MEM_WRITE;
                MEM_READ:    cs <= MEM_W_RF;
                EXEC:        cs <= ALU_W_RF;
                EXEC_I_JALR: cs <= ALU_W_PCN;
                ERROR:       cs <= ERROR; // held until reset
                default:     cs <= FETCH;
            endcase
        end
    end

    always_comb begin
        case (funct3)
            3'b000:  take_branch = ctrl.alu_flags.zero;                           // beq
            3'b001:  take_branch = ~ctrl.alu_flags.zero;                          // bne
            3'b100:  take_branch = ctrl.alu_flags.neg ^ ctrl.alu_flags.ov;        // blt
            3'b101:  take_branch = ~(ctrl.alu_flags.neg ^ ctrl.alu_flags.ov);     // bge
            3'b110:  take_branch = ~ctrl.alu_flags.cout;                          // bltu
            3'b111:  take_branch = ctrl.alu_flags.cout;                           // bgeu
            default: take_branch = 1'b0;
        endcase
    end

    always_comb begin
        case (funct3)
            3'b000:  mem_dt = MEM_DT_BYTE;
            3'b001:  mem_dt = MEM_DT_HALF;
            3'b010:  mem_dt = MEM_DT_WORD;
            3'b100:  mem_dt = MEM_DT_UBYTE;
            3'b101:  mem_dt = MEM_DT_UHALF;
            default: mem_dt = MEM_DT_NONE;
        endcase
    end

    // register ops ignore the immediate, shifts take only shamt
    assign exec_imm_src = (funct3[1:0] == 2'b01) ? IMM_SRC_ITYPE2 : IMM_SRC_ITYPE;

    rv_alu_dec i_alu_dec (
        .op     (op),
        .funct3 (funct3),
        .funct7 (funct7),
        .alu_op (alu_dec_op)
    );

    always_comb begin
        ctrl.rf_we      = 1'b0;
        ctrl.m_we       = 1'b0;
        ctrl.alu_src_a  = ALU_SRC_NONE;
        ctrl.alu_src_b  = ALU_SRC_NONE;
        ctrl.alu_ctrl   = ALU_OP_ADD;
        ctrl.res_src    = RES_SRC_NONE;
        ctrl.rf_wd_src  = RF_WD_SRC_RES;
        ctrl.imm_src    = IMM_SRC_NONE;
        ctrl.dt         = MEM_DT_NONE;
        ctrl.en_ir      = 1'b0;
        ctrl.en_npc_r   = 1'b0;
        ctrl.en_oldpc_r = 1'b0;
        ctrl.pc_src     = PC_SRC_RES;
        ctrl.m_addr_src = 1'b0;
        case (cs)
            FETCH: begin
                ctrl.alu_src_a  = ALU_SRC_PC;
                ctrl.alu_src_b  = ALU_SRC_4;
                ctrl.res_src    = RES_SRC_ALU;  // pc + 4 straight into pc
                ctrl.dt         = MEM_DT_WORD;
                ctrl.en_ir      = 1'b1;
                ctrl.en_npc_r   = 1'b1;
                ctrl.en_oldpc_r = 1'b1;
            end
            DECODE: begin
                ctrl.alu_src_a = ALU_SRC_PC_OLD;
                ctrl.alu_src_b = ALU_SRC_EXT_IMM;
                ctrl.imm_src   = (op == OP_J_TYPE) ? IMM_SRC_JTYPE : IMM_SRC_BTYPE;
            end
            MEM_ADDR: begin
                ctrl.alu_src_a = ALU_SRC_REG_1;
                ctrl.alu_src_b = ALU_SRC_EXT_IMM;
                ctrl.imm_src   = is_load ? IMM_SRC_ITYPE : IMM_SRC_STYPE;
                ctrl.dt        = mem_dt;
            end
            MEM_READ, MEM_WRITE: begin
                ctrl.alu_src_a  = ALU_SRC_REG_1;  // address stays in alu_out for the lane pick
                ctrl.alu_src_b  = ALU_SRC_EXT_IMM;
                ctrl.imm_src    = is_load ? IMM_SRC_ITYPE : IMM_SRC_STYPE;
                ctrl.m_we       = (cs == MEM_WRITE);
                ctrl.dt         = mem_dt;
                ctrl.m_addr_src = 1'b1;
            end
            MEM_W_RF: begin
                ctrl.rf_we      = 1'b1;
                ctrl.res_src    = RES_SRC_MEM;
                ctrl.dt         = mem_dt;   // drives load extension
                ctrl.m_addr_src = 1'b1;
            end
            EXEC: begin
                ctrl.alu_src_a = ALU_SRC_REG_1;
                ctrl.alu_src_b = (op == OP_R_TYPE) ? ALU_SRC_REG_2 : ALU_SRC_EXT_IMM;
                ctrl.alu_ctrl  = alu_dec_op;
                ctrl.imm_src   = exec_imm_src;
            end
            ALU_W_RF: begin
                ctrl.rf_we   = 1'b1;
                ctrl.res_src = RES_SRC_ALU_OUT;
            end
            BRANCH: begin
                ctrl.alu_src_a = ALU_SRC_REG_1;
                ctrl.alu_src_b = ALU_SRC_REG_2;
                ctrl.alu_ctrl  = alu_dec_op;
                ctrl.res_src   = RES_SRC_ALU_OUT; // target from decode
                ctrl.en_npc_r  = take_branch;
            end
            EXEC_J: begin
                ctrl.rf_we     = 1'b1;
                ctrl.rf_wd_src = RF_WD_SRC_PC;
                ctrl.res_src   = RES_SRC_ALU_OUT;
                ctrl.en_npc_r  = 1'b1;
            end
            EXEC_I_JALR: begin
                ctrl.rf_we     = 1'b1;
                ctrl.rf_wd_src = RF_WD_SRC_PC;
                ctrl.alu_src_a = ALU_SRC_REG_1;
                ctrl.alu_src_b = ALU_SRC_EXT_IMM;
                ctrl.imm_src   = IMM_SRC_ITYPE;
            end
            ALU_W_PCN: begin
                ctrl.res_src  = RES_SRC_ALU_OUT;
                ctrl.pc_src   = PC_SRC_RES_ALIGN;
                ctrl.en_npc_r = 1'b1;
            end
            EXEC_LUI: begin
                ctrl.rf_we     = 1'b1;
                ctrl.rf_wd_src = RF_WD_SRC_IMM;
                ctrl.imm_src   = IMM_SRC_UTYPE;
            end
            default: begin
                ctrl.alu_ctrl = ALU_OP_NONE; // error, everything idle
            end
        endcase
    end
endmodule

// File: hw/rv_imm_ext.sv
`timescale 1ns/1ps

module rv_imm_ext
    import rv_pkg::*;
(
    input  logic [31:0] instr,
    input  imm_src_e    imm_src,
    output logic [31:0] imm
);
    logic sign;

    assign sign = instr[31];

    always_comb begin
        case (imm_src)
            IMM_SRC_ITYPE:  imm = {{20{sign}}, instr[31:20]};
            IMM_SRC_ITYPE2: imm = {27'd0, instr[24:20]};  // shamt
            IMM_SRC_STYPE:  imm = {{20{sign}}, instr[31:25], instr[11:7]};
            IMM_SRC_BTYPE: begin
                imm = {{19{sign}}, sign, instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            IMM_SRC_JTYPE: begin
                imm = {{11{sign}}, sign, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            IMM_SRC_UTYPE:  imm = {instr[31:12], 12'd0};
            default:        imm = '0;
        endcase
    end
endmodule

// File: hw/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile (
    input  logic        clk,
    input  logic        rst,
    input  logic [4:0]  ra1,
    input  logic [4:0]  ra2,
    input  logic [4:0]  wa,
    input  logic [31:0] wd,
    input  logic        we,
    output logic [31:0] rd1,
    output logic [31:0] rd2
);
    logic [31:0] regs [32];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wa != 5'd0)) begin
            regs[wa] <= wd;
        end
    end

    assign rd1 = (ra1 == 5'd0) ? '0 : regs[ra1]; // x0 reads zero
    assign rd2 = (ra2 == 5'd0) ? '0 : regs[ra2];
endmodule

// File: hw/rv_alu.sv
`timescale 1ns/1ps

module rv_alu
    import rv_pkg::*;
(
    input  logic [31:0] a,
    input  logic [31:0] b,
    input  alu_op_e     op,
    output logic [31:0] result,
    output rv_flags_t   flags
);
    logic        sub;
    logic        arith;
    logic [31:0] b_eff;
    logic [32:0] sum;
    logic        ov;

    assign sub   = op inside {ALU_OP_SUB, ALU_OP_SLT, ALU_OP_SLTU};
    assign arith = op inside {ALU_OP_ADD, ALU_OP_SUB};
    assign b_eff = sub ? ~b : b;
    assign sum   = {1'b0, a} + {1'b0, b_eff} + {32'd0, sub}; // carry = no borrow on sub
    assign ov    = (a[31] == b_eff[31]) && (sum[31] != a[31]);

    always_comb begin
        case (op)
            ALU_OP_ADD, ALU_OP_SUB: result = sum[31:0];
            ALU_OP_AND:             result = a & b;
            ALU_OP_OR:              result = a | b;
            ALU_OP_XOR:             result = a ^ b;
            ALU_OP_SLL:             result = a << b[4:0];
            ALU_OP_SRL:             result = a >> b[4:0];
            ALU_OP_SRA:             result = $signed(a) >>> b[4:0];
            ALU_OP_SLT:             result = {31'd0, sum[31] ^ ov};
            ALU_OP_SLTU:            result = {31'd0, ~sum[32]};
            default:                result = '0;
        endcase
    end

    assign flags.neg  = result[31];
    assign flags.zero = (result == '0);
    assign flags.cout = arith & sum[32];
    assign flags.ov   = arith & ov;
endmodule

// File: hw/rv_alu_dec.sv
`timescale 1ns/1ps

module rv_alu_dec
    import rv_pkg::*;
(
    input  logic [6:0] op,
    input  logic [2:0] funct3,
    input  logic [6:0] funct7,
    output alu_op_e    alu_op
);
    alu_op_e arith_op;
    logic    sub_en;

    assign sub_en = (op == OP_R_TYPE) & funct7[5]; // addi has no sub form

    always_comb begin
        case (funct3)
            3'b000:  arith_op = sub_en ? ALU_OP_SUB : ALU_OP_ADD;
            3'b001:  arith_op = ALU_OP_SLL;
            3'b010:  arith_op = ALU_OP_SLT;
            3'b011:  arith_op = ALU_OP_SLTU;
            3'b100:  arith_op = ALU_OP_XOR;
            3'b101:  arith_op = funct7[5] ? ALU_OP_SRA : ALU_OP_SRL;
            3'b110:  arith_op = ALU_OP_OR;
            default: arith_op = ALU_OP_AND;
        endcase
    end

    always_comb begin
        case (op)
            OP_R_TYPE, OP_I_TYPE:            alu_op = arith_op;
            OP_B_TYPE:                       alu_op = ALU_OP_SUB; // compare via flags
            OP_I_TYPE_L, OP_S_TYPE, OP_JALR: alu_op = ALU_OP_ADD;
            default:                         alu_op = ALU_OP_NONE;
        endcase
    end
endmodule

// File: hw/rv_ctrl_if.sv
`timescale 1ns/1ps

interface rv_ctrl_if
    import rv_pkg::*;
();
    logic       rf_we;
    logic       m_we;
    alu_src_e   alu_src_a;
    alu_src_e   alu_src_b;
    alu_op_e    alu_ctrl;
    res_src_e   res_src;
    rf_wd_src_e rf_wd_src;
    imm_src_e   imm_src;
    mem_dt_e    dt;
    logic       en_ir;
    logic       en_npc_r;
    logic       en_oldpc_r;
    pc_src_e    pc_src;
    logic       m_addr_src;   // 1 selects alu_out as address
    logic [31:0] instr;
    rv_flags_t  alu_flags;

    modport ctrl (
        output rf_we, m_we, alu_src_a, alu_src_b, alu_ctrl, res_src, rf_wd_src, imm_src,
               dt, en_ir, en_npc_r, en_oldpc_r, pc_src, m_addr_src,
        input  instr, alu_flags
    );

    modport dp (
        input  rf_we, m_we, alu_src_a, alu_src_b, alu_ctrl, res_src, rf_wd_src, imm_src,
               dt, en_ir, en_npc_r, en_oldpc_r, pc_src, m_addr_src,
        output instr, alu_flags
    );
endinterface

// File: hw/rv_pkg.sv
package rv_pkg;

    // RV32I major opcodes
    localparam logic [6:0] OP_R_TYPE   = 7'b0110011;
    localparam logic [6:0] OP_I_TYPE   = 7'b0010011;
    localparam logic [6:0] OP_I_TYPE_L = 7'b0000011; // loads
    localparam logic [6:0] OP_S_TYPE   = 7'b0100011;
    localparam logic [6:0] OP_B_TYPE   = 7'b1100011;
    localparam logic [6:0] OP_J_TYPE   = 7'b1101111; // jal
    localparam logic [6:0] OP_JALR     = 7'b1100111;
    localparam logic [6:0] OP_LUI      = 7'b0110111;

    typedef enum logic [2:0] {
        ALU_SRC_PC,
        ALU_SRC_PC_OLD,
        ALU_SRC_REG_1,
        ALU_SRC_4,
        ALU_SRC_EXT_IMM,
        ALU_SRC_REG_2,
        ALU_SRC_NONE
    } alu_src_e;

    typedef enum logic [1:0] {
        RES_SRC_ALU,
        RES_SRC_ALU_OUT,
        RES_SRC_MEM,
        RES_SRC_NONE
    } res_src_e;

    typedef enum logic [1:0] {
        RF_WD_SRC_RES,
        RF_WD_SRC_PC,  // link value
        RF_WD_SRC_IMM
    } rf_wd_src_e;

    typedef enum logic [2:0] {
        IMM_SRC_NONE,
        IMM_SRC_ITYPE,
        IMM_SRC_ITYPE2, // shamt only
        IMM_SRC_STYPE,
        IMM_SRC_BTYPE,
        IMM_SRC_JTYPE,
        IMM_SRC_UTYPE
    } imm_src_e;

    typedef enum logic [3:0] {
        ALU_OP_ADD,
        ALU_OP_SUB,
        ALU_OP_AND,
        ALU_OP_OR,
        ALU_OP_XOR,
        ALU_OP_SLL,
        ALU_OP_SRL,
        ALU_OP_SRA,
        ALU_OP_SLT,
        ALU_OP_SLTU,
        ALU_OP_NONE
    } alu_op_e;

    typedef enum logic [2:0] {
        MEM_DT_NONE,
        MEM_DT_BYTE,
        MEM_DT_HALF,
        MEM_DT_WORD,
        MEM_DT_UBYTE,
        MEM_DT_UHALF
    } mem_dt_e;

    typedef enum logic {
        PC_SRC_RES,
        PC_SRC_RES_ALIGN // jalr, bit 0 cleared
    } pc_src_e;

    typedef struct packed {
        logic neg;
        logic zero;
        logic cout;
        logic ov;
    } rv_flags_t;

endpackage
